//--- source/core_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core sizing for the 16-bit teaching core.
// addresses are byte addresses, instructions are one word.
// changing WORD_W alone does not retarget the ISA fields.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and bus address width.
`define WORD_W 16

// register file size and index width, kept consistent by hand.
`define NUM_REGS 8
`define REG_AW 3

// first fetch address after reset.
`define RESET_PC 16'h0000

`endif

//--- source/isaPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ISA encodings for the teaching core.
// opcode sits in bits 15..11; undefined codes behave as HALT.
// all-zero memory therefore reads as HALT.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package isaPkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // opcodes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,   // stop the core.
      OP_ADD  = 5'b00001,   // rd = rs + rt.
      OP_SUB  = 5'b00010,   // rd = rs - rt.
      OP_XOR  = 5'b00011,   // rd = rs ^ rt.
      OP_ADDI = 5'b00100,   // rd = rs + sext(imm5).
      OP_BEQZ = 5'b01000,   // branch if reg is zero.
      OP_BNEZ = 5'b01001,   // branch if reg is not zero.
      OP_J    = 5'b01010    // unconditional pc-relative jump.
   } opcodeT;

   typedef enum logic [1:0] {
      ALU_ADD  = 2'b00,
      ALU_SUB  = 2'b01,
      ALU_XOR  = 2'b10,
      ALU_PASS = 2'b11      // operand a straight through.
   } aluOpT;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // field positions and widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int OPC_W   = 5;   // opcode width.
   localparam int OPC_LSB = 11;  // opcode low bit.
   localparam int REG_W   = 3;   // register field width.
   localparam int RD_LSB  = 8;   // rd, also the branch test register.
   localparam int RS_LSB  = 5;
   localparam int RT_LSB  = 2;
   localparam int IMM_W   = 5;   // ADDI signed immediate.
   localparam int BOFF_W  = 8;   // branch signed word offset.
   localparam int JOFF_W  = 11;  // jump signed word offset.

endpackage

//--- source/busPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus-side types for the fetch unit.
// wishbone classic, single reads only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package busPkg;

   // fetch cycle states.
   // FS_HOLD waits for a control transfer to resolve.
   // FS_DONE is terminal until reset.
   typedef enum logic [1:0] {
      FS_IDLE = 2'b00,   // no bus cycle, may start one.
      FS_BUS  = 2'b01,   // cyc/stb high, waiting for ack or err.
      FS_HOLD = 2'b10,   // branch or jump in flight.
      FS_DONE = 2'b11    // halted or bus error.
   } fetchStateT;

endpackage

//--- source/regFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file, two async reads and one write.
// a write is visible to a same-cycle read of that index.
// r0 is an ordinary register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_params.svh"

module regFile (
   input  logic               clk,
   input  logic               arstN,
   input  logic [`REG_AW-1:0] rdAddrA,
   input  logic [`REG_AW-1:0] rdAddrB,
   output logic [`WORD_W-1:0] rdDataA,
   output logic [`WORD_W-1:0] rdDataB,
   input  logic               wrEn,
   input  logic [`REG_AW-1:0] wrAddr,
   input  logic [`WORD_W-1:0] wrData
);

   logic [`WORD_W-1:0] regs [`NUM_REGS];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `NUM_REGS; i++)
            regs[i] <= '0;
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // bypass covers the writeback cycle.
   assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

//--- source/fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch over wishbone classic, one read per word.
// no speculation: after a branch or jump, fetch waits for resolve.
// HALT or err stops fetch until reset.
// a new read starts only when the instruction register is free.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_params.svh"

module fetch
   import busPkg::*, isaPkg::*;
(
   input  logic               clk,
   input  logic               arstN,
   // wishbone master, read only
   output logic               cyc,
   output logic               stb,
   output logic               we,
   output logic [`WORD_W-1:0] adr,
   input  logic [`WORD_W-1:0] datIn,
   input  logic               ack,
   input  logic               busErr,
   // to decode
   input  logic               dStall,
   output logic [`WORD_W-1:0] fInstr,
   output logic [`WORD_W-1:0] fPc,
   output logic               fValid,
   // from execute
   input  logic               redirect,
   input  logic [`WORD_W-1:0] redirectPc,
   input  logic               resolve,
   output logic               err
);

   fetchStateT         state;
   fetchStateT         ackNext;    // state to take on ack.
   logic [`WORD_W-1:0] pc;
   logic               slotFree;   // instr register empty or draining.
   logic               capture;

   assign slotFree = !fValid || !dStall;
   assign capture  = (state == FS_BUS) && ack && !busErr;

   assign cyc = (state == FS_BUS);
   assign stb = (state == FS_BUS);
   assign we  = 1'b0;   // never writes.
   assign adr = pc;

   // predecode of the incoming word.
   always_comb begin
      case (datIn[OPC_LSB +: OPC_W])
         OP_BEQZ, OP_BNEZ, OP_J:          ackNext = FS_HOLD;
         OP_ADD, OP_SUB, OP_XOR, OP_ADDI: ackNext = FS_IDLE;
         default:                         ackNext = FS_DONE;   // halt or undefined.
      endcase
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // fetch control
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         state  <= FS_IDLE;
         pc     <= `RESET_PC;
         fValid <= 1'b0;
         err    <= 1'b0;
      end else begin
         if (fValid && !dStall)
            fValid <= 1'b0;   // decode took it.
         case (state)
            FS_IDLE: begin
               if (slotFree)
                  state <= FS_BUS;
            end
            FS_BUS: begin
               if (busErr) begin
                  err   <= 1'b1;   // sticky.
                  state <= FS_DONE;
               end else if (ack) begin
                  fValid <= 1'b1;
                  pc     <= pc + `WORD_W'(2);
                  state  <= ackNext;
               end
            end
            FS_HOLD: begin
               if (resolve) begin
                  if (redirect)
                     pc <= redirectPc;   // taken.
                  state <= FS_IDLE;
               end
            end
            default: state <= FS_DONE;   // stays stopped.
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         fInstr <= datIn;
         fPc    <= pc;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // checks
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   aStbCyc: assert property (@(posedge clk) disable iff (!arstN) stb |-> cyc);
   aAdrHold: assert property (@(posedge clk) disable iff (!arstN)
      (stb && !ack && !busErr) |=> $stable(adr) && stb);
   aRedirHold: assert property (@(posedge clk) disable iff (!arstN)
      redirect |-> state == FS_HOLD);   // only while a transfer is pending.

endmodule

//--- source/decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage with the register file and the D/X register.
// stalls one cycle when a source matches the dest in execute.
// no forwarding; the regFile bypass covers writeback.
// xOffset is a sign-extended word offset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_params.svh"

module decode
   import isaPkg::*;
(
   input  logic               clk,
   input  logic               arstN,
   input  logic [`WORD_W-1:0] fInstr,
   input  logic [`WORD_W-1:0] fPc,
   input  logic               fValid,
   output logic               dStall,
   input  logic               wrEn,
   input  logic [`REG_AW-1:0] wrAddr,
   input  logic [`WORD_W-1:0] wrData,
   output logic               xValid,
   output opcodeT             xOp,
   output aluOpT              xAluOp,
   output logic [`REG_AW-1:0] xRd,
   output logic               xWrEn,
   output logic [`WORD_W-1:0] xOpA,
   output logic [`WORD_W-1:0] xOpB,
   output logic [`WORD_W-1:0] xPc,
   output logic [`WORD_W-1:0] xOffset
);

   opcodeT             op;
   aluOpT              aluOp;
   logic               wrEnD;
   logic               useA, useB;       // source reads needed.
   logic [`REG_AW-1:0] rdAddrA, rdAddrB;
   logic [`WORD_W-1:0] rdDataA, rdDataB;
   logic [`WORD_W-1:0] imm, offset;
   logic               hazard;

   regFile rf0 (
      .clk(clk), .arstN(arstN),
      .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
      .rdDataA(rdDataA), .rdDataB(rdDataB),
      .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
   );

   assign imm = {{(`WORD_W-IMM_W){fInstr[IMM_W-1]}}, fInstr[IMM_W-1:0]};

   always_comb begin
      op      = OP_HALT;   // undefined decodes as halt.
      aluOp   = ALU_PASS;
      wrEnD   = 1'b0;
      useA    = 1'b0;
      useB    = 1'b0;
      rdAddrA = fInstr[RS_LSB +: REG_W];
      rdAddrB = fInstr[RT_LSB +: REG_W];
      offset  = '0;
      case (fInstr[OPC_LSB +: OPC_W])
         OP_ADD:  begin op = OP_ADD; aluOp = ALU_ADD; wrEnD = 1'b1; useA = 1'b1; useB = 1'b1; end
         OP_SUB:  begin op = OP_SUB; aluOp = ALU_SUB; wrEnD = 1'b1; useA = 1'b1; useB = 1'b1; end
         OP_XOR:  begin op = OP_XOR; aluOp = ALU_XOR; wrEnD = 1'b1; useA = 1'b1; useB = 1'b1; end
         OP_ADDI: begin op = OP_ADDI; aluOp = ALU_ADD; wrEnD = 1'b1; useA = 1'b1; end
         OP_BEQZ, OP_BNEZ: begin
            op      = (fInstr[OPC_LSB +: OPC_W] == OP_BEQZ) ? OP_BEQZ : OP_BNEZ;
            rdAddrA = fInstr[RD_LSB +: REG_W];   // tested register.
            useA    = 1'b1;
            offset  = {{(`WORD_W-BOFF_W){fInstr[BOFF_W-1]}}, fInstr[BOFF_W-1:0]};
         end
         OP_J: begin
            op     = OP_J;
            offset = {{(`WORD_W-JOFF_W){fInstr[JOFF_W-1]}}, fInstr[JOFF_W-1:0]};
         end
         default: ;
      endcase
   end

   // dest in execute is taken from our own output register.
   assign hazard = xValid && xWrEn &&
                   ((useA && (rdAddrA == xRd)) || (useB && (rdAddrB == xRd)));
   assign dStall = fValid && hazard;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // decode/execute register
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN)
         xValid <= 1'b0;
      else
         xValid <= fValid && !hazard;   // bubble on stall.
   end

   always_ff @(posedge clk) begin
      if (fValid && !hazard) begin
         xOp     <= op;
         xAluOp  <= aluOp;
         xRd     <= fInstr[RD_LSB +: REG_W];
         xWrEn   <= wrEnD;
         xOpA    <= rdDataA;
         xOpB    <= (op == OP_ADDI) ? imm : rdDataB;
         xPc     <= fPc;
         xOffset <= offset;
      end
   end

   aBubble: assert property (@(posedge clk) disable iff (!arstN) dStall |=> !xValid);

endmodule

//--- source/execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage and the writeback register.
// branch target is pc + 2 + 2*offset, arithmetic wraps at 16 bits.
// redirect and resolve are one-cycle pulses.
// halted is sticky once a HALT executes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_params.svh"

module execute
   import isaPkg::*;
(
   input  logic               clk,
   input  logic               arstN,
   input  logic               xValid,
   input  opcodeT             xOp,
   input  aluOpT              xAluOp,
   input  logic [`REG_AW-1:0] xRd,
   input  logic               xWrEn,
   input  logic [`WORD_W-1:0] xOpA,
   input  logic [`WORD_W-1:0] xOpB,
   input  logic [`WORD_W-1:0] xPc,
   input  logic [`WORD_W-1:0] xOffset,
   output logic               redirect,
   output logic [`WORD_W-1:0] redirectPc,
   output logic               resolve,
   output logic               halted,
   output logic               wbEn,
   output logic [`REG_AW-1:0] wbReg,
   output logic [`WORD_W-1:0] wbData
);

   logic [`WORD_W-1:0] aluRes;
   logic [`WORD_W-1:0] target;
   logic               isCtl;
   logic               taken;

   always_comb begin
      case (xAluOp)
         ALU_ADD: aluRes = xOpA + xOpB;
         ALU_SUB: aluRes = xOpA - xOpB;
         ALU_XOR: aluRes = xOpA ^ xOpB;
         default: aluRes = xOpA;
      endcase
   end

   always_comb begin
      isCtl = 1'b1;
      case (xOp)
         OP_BEQZ: taken = (xOpA == '0);
         OP_BNEZ: taken = (xOpA != '0);
         OP_J:    taken = 1'b1;
         default: begin
            isCtl = 1'b0;
            taken = 1'b0;
         end
      endcase
   end

   assign target = xPc + `WORD_W'(2) + (xOffset << 1);

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         wbEn     <= 1'b0;
         redirect <= 1'b0;
         resolve  <= 1'b0;
         halted   <= 1'b0;
      end else begin
         wbEn     <= xValid && xWrEn;
         redirect <= xValid && isCtl && taken;
         resolve  <= xValid && isCtl;   // taken or not.
         if (xValid && (xOp == OP_HALT))
            halted <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      wbReg      <= xRd;
      wbData     <= aluRes;
      redirectPc <= target;
   end

   aNoWbAfterHalt: assert property (@(posedge clk) disable iff (!arstN) halted |=> !wbEn);

endmodule

//--- source/coreTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core top: fetch, decode, execute.
// instruction bus is wishbone classic, read only.
// halted also covers a bus error.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_params.svh"

module coreTop
   import isaPkg::*;
(
   input  logic               clk,
   input  logic               arstN,
   output logic               cyc,
   output logic               stb,
   output logic               we,
   output logic [`WORD_W-1:0] adr,
   input  logic [`WORD_W-1:0] datIn,
   input  logic               ack,
   input  logic               busErr,
   output logic               wbEn,
   output logic [`REG_AW-1:0] wbReg,
   output logic [`WORD_W-1:0] wbData,
   output logic               halted,
   output logic               err
);

   logic [`WORD_W-1:0] fInstr, fPc, redirectPc;
   logic               fValid, dStall, redirect, resolve;
   logic               xValid, xWrEn, exHalted;
   opcodeT             xOp;
   aluOpT              xAluOp;
   logic [`REG_AW-1:0] xRd;
   logic [`WORD_W-1:0] xOpA, xOpB, xPc, xOffset;

   fetch fetch0 (
      .clk(clk), .arstN(arstN),
      .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .datIn(datIn), .ack(ack), .busErr(busErr),
      .dStall(dStall), .fInstr(fInstr), .fPc(fPc), .fValid(fValid),
      .redirect(redirect), .redirectPc(redirectPc), .resolve(resolve), .err(err)
   );

   decode decode0 (
      .clk(clk), .arstN(arstN),
      .fInstr(fInstr), .fPc(fPc), .fValid(fValid), .dStall(dStall),
      .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData),
      .xValid(xValid), .xOp(xOp), .xAluOp(xAluOp), .xRd(xRd), .xWrEn(xWrEn),
      .xOpA(xOpA), .xOpB(xOpB), .xPc(xPc), .xOffset(xOffset)
   );

   execute execute0 (
      .clk(clk), .arstN(arstN),
      .xValid(xValid), .xOp(xOp), .xAluOp(xAluOp), .xRd(xRd), .xWrEn(xWrEn),
      .xOpA(xOpA), .xOpB(xOpB), .xPc(xPc), .xOffset(xOffset),
      .redirect(redirect), .redirectPc(redirectPc), .resolve(resolve),
      .halted(exHalted), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
   );

   assign halted = exHalted | err;   // err stops the core too.

endmodule

//--- verif/clkGen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source.
// 4 ns clock; arstN is low while rstReq is high
// and for 16 rising edges after rstReq drops.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module clkGen (
   input  logic rstReq,
   output logic clk,
   output logic arstN
);
   timeunit 1ns;
   timeprecision 100ps;

   int holdCnt = 0;   // edges since reset request.

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;   // 4 ns period.
   end

   always @(posedge clk or posedge rstReq) begin
      if (rstReq)
         holdCnt <= 0;
      else if (holdCnt < 16)
         holdCnt <= holdCnt + 1;
   end

   assign arstN = (holdCnt >= 16);

endmodule

//--- verif/wbMemModel.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic instruction memory, reads only.
// 256 words, indexed by adr[8:1]; higher address bits wrap.
// 0 to 3 wait states per read from $random, seed 77699.
// one address may be set to answer with err instead of ack.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_params.svh"

module wbMemModel (
   input  logic               clk,
   input  logic               cyc,
   input  logic               stb,
   input  logic               we,
   input  logic [`WORD_W-1:0] adr,
   output logic [`WORD_W-1:0] datOut,
   output logic               ack,
   output logic               err
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [`WORD_W-1:0] mem [256];
   logic [`WORD_W-1:0] datR     = '0;
   logic               ackR     = 1'b0;
   logic               errR     = 1'b0;
   logic               errOn    = 1'b0;
   logic [`WORD_W-1:0] errAdr   = '0;
   logic               busy     = 1'b0;   // a read is counting wait states.
   int                 waitLeft = 0;
   int                 seed     = 77699;

   assign datOut = datR;
   assign ack    = ackR;
   assign err    = errR;

   task automatic writeWord(input int idx, input logic [`WORD_W-1:0] w);
      mem[idx] = w;
   endtask

   task automatic setErrAddr(input logic en, input logic [`WORD_W-1:0] a);
      errOn  = en;
      errAdr = a;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // read response
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge clk) begin
      ackR <= 1'b0;
      errR <= 1'b0;
      if (!cyc) begin
         busy = 1'b0;
      end else if (stb && !ackR && !errR && !we) begin
         if (!busy) begin
            busy     = 1'b1;
            waitLeft = $random(seed) & 3;   // new read, pick its latency.
         end
         if (waitLeft == 0) begin
            busy = 1'b0;
            datR <= mem[adr[8:1]];
            if (errOn && (adr == errAdr))
               errR <= 1'b1;
            else
               ackR <= 1'b1;
         end else begin
            waitLeft = waitLeft - 1;
         end
      end
   end

endmodule

//--- verif/coreTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed tests for the pipelined core.
// each test assembles a program, runs it from reset and
// compares writebacks and fetch addresses with an ISA model.
// programs must end in HALT within 1000 executed steps.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "core_params.svh"

module coreTb
   import isaPkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MEM_WORDS = 256;
   localparam int HALT_WAIT = 2000;   // cycles allowed to reach halted.
   localparam int TR_W      = `REG_AW + `WORD_W;

   logic               clk, arstN;
   logic               rstReq = 1'b0;
   logic               cyc, stb, we, ack, busErr;
   logic [`WORD_W-1:0] adr, datIn;
   logic               wbEn, halted, coreErr;
   logic [`REG_AW-1:0] wbReg;
   logic [`WORD_W-1:0] wbData;

   logic [`WORD_W-1:0] image [MEM_WORDS];   // program as loaded.
   int                 progLen;
   logic               errOn;
   logic [`WORD_W-1:0] errAdr;
   logic               expErr;
   logic [TR_W-1:0]    traceQ[$], expTraceQ[$];
   logic [`WORD_W-1:0] fetchQ[$], expFetchQ[$];

   clkGen clkGen0 (.rstReq(rstReq), .clk(clk), .arstN(arstN));

   wbMemModel mem0 (
      .clk(clk), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .datOut(datIn), .ack(ack), .err(busErr)
   );

   coreTop dut0 (
      .clk(clk), .arstN(arstN), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .datIn(datIn), .ack(ack), .busErr(busErr), .wbEn(wbEn), .wbReg(wbReg),
      .wbData(wbData), .halted(halted), .err(coreErr)
   );

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "stopped at first error");
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // assembler
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [15:0] encReg(input opcodeT op, input int rd, input int rs,
                                          input int rt);
      return {op, rd[2:0], rs[2:0], rt[2:0], 2'b00};
   endfunction

   function automatic logic [15:0] encAddi(input int rd, input int rs, input int imm);
      return {OP_ADDI, rd[2:0], rs[2:0], imm[4:0]};
   endfunction

   function automatic logic [15:0] encBranch(input opcodeT op, input int r, input int off);
      return {op, r[2:0], off[7:0]};
   endfunction

   function automatic logic [15:0] encJump(input int off);
      return {OP_J, off[10:0]};
   endfunction

   function automatic logic [15:0] encHalt();
      return {OP_HALT, 11'd0};
   endfunction

   task automatic newProgram();
      for (int i = 0; i < MEM_WORDS; i++)
         image[i] = {5'b11111, 3'b000, i[7:0]};   // undefined opcode, runs as halt.
      progLen = 0;
      errOn   = 1'b0;
      errAdr  = '0;
   endtask

   task automatic emit(input logic [15:0] w);
      image[progLen] = w;
      progLen++;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // ISA reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic predict();
      logic [15:0] regs [`NUM_REGS];
      logic [15:0] pc, w, res;
      logic [2:0]  rd, rs, rt;
      logic        done, wr;
      int          steps;
      expTraceQ.delete();
      expFetchQ.delete();
      for (int i = 0; i < `NUM_REGS; i++)
         regs[i] = '0;
      pc     = `RESET_PC;
      expErr = 1'b0;
      done   = 1'b0;
      steps  = 0;
      while (!done) begin
         expFetchQ.push_back(pc);
         if (errOn && (pc == errAdr)) begin
            expErr = 1'b1;   // read fails, nothing from here on.
            done   = 1'b1;
         end else begin
            w   = image[pc[8:1]];
            rd  = w[10:8];
            rs  = w[7:5];
            rt  = w[4:2];
            pc  = pc + 16'd2;
            wr  = 1'b1;
            res = '0;
            case (w[15:11])
               OP_ADD:  res = regs[rs] + regs[rt];
               OP_SUB:  res = regs[rs] - regs[rt];
               OP_XOR:  res = regs[rs] ^ regs[rt];
               OP_ADDI: res = regs[rs] + {{11{w[4]}}, w[4:0]};
               OP_BEQZ, OP_BNEZ: begin
                  wr = 1'b0;
                  if ((regs[rd] == '0) == (w[15:11] == OP_BEQZ))
                     pc = pc + {{7{w[7]}}, w[7:0], 1'b0};
               end
               OP_J: begin
                  wr = 1'b0;
                  pc = pc + {{4{w[10]}}, w[10:0], 1'b0};
               end
               default: begin
                  wr   = 1'b0;
                  done = 1'b1;   // halt and undefined codes.
               end
            endcase
            if (wr) begin
               regs[rd] = res;
               expTraceQ.push_back({rd, res});
            end
         end
         steps++;
         if (steps > 1000)
            abortRun("reference model ran 1000 steps without reaching HALT");
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bus and writeback monitor
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(posedge clk) begin
      if (arstN) begin
         if (wbEn)
            traceQ.push_back({wbReg, wbData});
         if (cyc && stb && (ack || busErr))
            fetchQ.push_back(adr);   // one entry per finished read.
         assert (cyc || !stb)
            else abortRun("stb was high while cyc was low");
         assert (!cyc || !we)
            else abortRun("FAILED we: got 0x1, expected 0x0");
         assert (!stb || !adr[0])
            else abortRun($sformatf("FAILED adr: got 0x%h, expected an even address", adr));
      end
   end

   task automatic checkResults(input string name);
      assert (coreErr == expErr)
         else abortRun($sformatf("FAILED err: got 0x%h, expected 0x%h in %s",
                                 coreErr, expErr, name));
      assert (traceQ.size() == expTraceQ.size())
         else abortRun($sformatf("%s: the DUT wrote back %0d results but the model expects %0d",
                                 name, traceQ.size(), expTraceQ.size()));
      foreach (expTraceQ[i]) begin
         assert (traceQ[i][`WORD_W +: `REG_AW] == expTraceQ[i][`WORD_W +: `REG_AW])
            else abortRun($sformatf("FAILED wbReg at write %0d of %s: got 0x%h, expected 0x%h",
                      i, name, traceQ[i][`WORD_W +: `REG_AW], expTraceQ[i][`WORD_W +: `REG_AW]));
         assert (traceQ[i][`WORD_W-1:0] == expTraceQ[i][`WORD_W-1:0])
            else abortRun($sformatf("FAILED wbData at write %0d of %s: got 0x%h, expected 0x%h",
                      i, name, traceQ[i][`WORD_W-1:0], expTraceQ[i][`WORD_W-1:0]));
      end
      assert (fetchQ.size() == expFetchQ.size())
         else abortRun($sformatf("%s: the DUT made %0d reads but the model expects %0d",
                                 name, fetchQ.size(), expFetchQ.size()));
      foreach (expFetchQ[i])
         assert (fetchQ[i] == expFetchQ[i])
            else abortRun($sformatf("FAILED adr at read %0d of %s: got 0x%h, expected 0x%h",
                                    i, name, fetchQ[i], expFetchQ[i]));
   endtask

   // load, reset, run to halted, then watch the bus stay quiet.
   task automatic runProgram(input string name);
      int n;
      @(posedge clk);
      rstReq <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < MEM_WORDS; i++)
         mem0.writeWord(i, image[i]);
      mem0.setErrAddr(errOn, errAdr);
      predict();
      traceQ.delete();
      fetchQ.delete();
      @(posedge clk);
      rstReq <= 1'b0;
      n = 0;
      while (!arstN && n < 40) begin
         @(posedge clk);
         n++;
      end
      if (!arstN)
         abortRun($sformatf("%s: reset was not released within 40 cycles", name));
      n = 0;
      while (!halted && n < HALT_WAIT) begin
         @(posedge clk);
         n++;
      end
      if (!halted)
         abortRun($sformatf("%s: timed out after %0d cycles waiting for halted", name, n));
      repeat (50) begin
         @(posedge clk);
         assert (!cyc)
            else abortRun($sformatf("FAILED cyc: got 0x%h, expected 0x0 after halted", cyc));
      end
      checkResults(name);
      $display("%s: %0d writes, %0d reads checked", name, traceQ.size(), fetchQ.size());
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // directed tests
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic testAluChain();
      newProgram();
      emit(encAddi(1, 0, 7));
      emit(encAddi(2, 0, -4));
      emit(encAddi(4, 0, 15));
      emit(encReg(OP_ADD, 3, 1, 2));
      emit(encReg(OP_SUB, 5, 1, 4));
      emit(encReg(OP_XOR, 6, 3, 5));
      emit(encAddi(0, 0, -16));   // r0 is writable.
      emit(encReg(OP_SUB, 7, 0, 6));
      emit(encHalt());
      runProgram("aluChain");
   endtask

   task automatic testDependent();
      newProgram();
      emit(encAddi(1, 1, 3));
      emit(encAddi(1, 1, 3));
      emit(encAddi(1, 1, -1));
      emit(encReg(OP_ADD, 2, 1, 1));
      emit(encReg(OP_ADD, 2, 2, 2));
      emit(encReg(OP_XOR, 3, 2, 1));
      emit(encReg(OP_SUB, 3, 3, 3));
      emit(encHalt());
      runProgram("dependent");
   endtask

   task automatic testBranches();
      newProgram();
      emit(encAddi(1, 0, 0));            // 0
      emit(encBranch(OP_BEQZ, 1, 1));    // 2, taken to 6.
      emit(encAddi(7, 0, 1));            // 4, skipped.
      emit(encBranch(OP_BNEZ, 1, 1));    // 6, not taken.
      emit(encAddi(2, 0, 3));            // 8, loop count.
      emit(encAddi(3, 3, 2));            // 10, loop body.
      emit(encAddi(2, 2, -1));           // 12
      emit(encBranch(OP_BEQZ, 2, 2));    // 14, exit to 20.
      emit(encJump(-4));                 // 16, back to 10.
      emit(encAddi(7, 0, 2));            // 18, skipped.
      emit(encBranch(OP_BNEZ, 3, 1));    // 20, taken to 24.
      emit(encAddi(7, 0, 3));            // 22, skipped.
      emit(encHalt());                   // 24
      runProgram("branches");
      foreach (traceQ[i])
         assert (traceQ[i][`WORD_W +: `REG_AW] != `REG_AW'(7))
            else abortRun("an instruction after a taken branch reached writeback");
   endtask

   task automatic testHalt();
      newProgram();
      emit(encAddi(1, 0, 1));
      emit(encAddi(2, 0, 2));
      emit(encHalt());
      emit(encAddi(3, 0, 3));   // never runs.
      emit(encAddi(4, 0, 4));
      runProgram("halt");
   endtask

   task automatic testBusErr();
      newProgram();
      emit(encAddi(1, 0, 1));
      emit(encAddi(2, 1, 1));
      emit(encReg(OP_ADD, 3, 1, 2));
      emit(encAddi(4, 0, 4));   // read at 6 answers with err.
      emit(encHalt());
      errOn  = 1'b1;
      errAdr = 16'h0006;
      runProgram("busErr");
   endtask

   initial begin
      testAluChain();
      testDependent();
      testBranches();
      testHalt();
      testBusErr();
      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+source
source/isaPkg.sv
source/busPkg.sv
source/regFile.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/coreTop.sv
verif/clkGen.sv
verif/wbMemModel.sv
verif/coreTb.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      ?= coreTb
FILELIST ?= vlog.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	-./$(BUILD)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
